//--- Bender.yml
package:
  name: mem_subsys

sources:
  # packages first
  - rtl/bus_pkg.sv
  - rtl/core_if_pkg.sv
  # leaf modules, then the top level
  - rtl/clint_timer.sv
  - rtl/serial_tx_port.sv
  - rtl/axi_sram.sv
  - rtl/bus_arbiter.sv
  - rtl/mem_subsys_top.sv
  - target: test
    files:
      - dv/tb_mem_subsys.sv

//--- dv/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
  import bus_pkg::*;
  import core_if_pkg::*;
();

  localparam int SRAM_WORDS = 1024;
  localparam int READ_LAT   = 2;
  localparam int TIMEOUT    = 200;

  typedef enum logic [1:0] {REQ_IFU, REQ_LSU, REQ_BOTH} req_who_e;
  typedef enum logic [2:0] {CHK_NONE, CHK_MODEL, CHK_VALUE, CHK_RISE, CHK_TX} chk_e;

  // one table row, addr2 is the ifu address when both requesters run
  typedef struct packed {
    req_who_e    who;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] addr2;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp;
    chk_e        chk;
    logic [7:0]  gap;
  } row_t;

  logic        clk;
  logic        rst;
  ifu_req_t    ifu_req;
  ifu_rsp_t    ifu_rsp;
  lsu_req_t    lsu_req;
  lsu_rsp_t    lsu_rsp;
  uart_tx_t    uart_tx;

  row_t        rows[$];
  logic [31:0] ref_mem [2*SRAM_WORDS];
  integer      seed;
  int          errors;
  int          passed;
  int          failed;
  int          tx_count;
  int          tx_expect;
  logic [7:0]  tx_last;
  logic [31:0] last_lo;
  logic        timed_out;

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  mem_subsys_top #(
    .SRAM_WORDS (SRAM_WORDS),
    .READ_LAT   (READ_LAT)
  ) u_mem_subsys_top (
    .clk       (clk),
    .rst       (rst),
    .ifu_req_i (ifu_req),
    .ifu_rsp_o (ifu_rsp),
    .lsu_req_i (lsu_req),
    .lsu_rsp_o (lsu_rsp),
    .uart_tx_o (uart_tx)
  );

  // counts every byte the serial port emits
  always @(negedge clk)
  begin
    if (!rst && uart_tx.valid)
    begin
      tx_count = tx_count + 1;
      tx_last  = uart_tx.data;
    end
  end

  // byte-strobe rule of the reference model
  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
      input logic [31:0] wdata, input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  function automatic void add_row(input req_who_e who, input logic wr,
      input logic [31:0] addr, input logic [31:0] addr2, input logic [31:0] wdata,
      input logic [3:0] wstrb, input logic [31:0] exp, input chk_e chk, input int gap);
    row_t r;
    r.who   = who;
    r.wr    = wr;
    r.addr  = addr;
    r.addr2 = addr2;
    r.wdata = wdata;
    r.wstrb = wstrb;
    r.exp   = exp;
    r.chk   = chk;
    r.gap   = gap[7:0];
    rows.push_back(r);
  endfunction

  task automatic fail_check(input int n, input string msg);
    $display("FAILED @%0t ns: row %0d: %s", $time, n, msg);
    errors++;
  endtask

  task automatic apply_row(input int n, input row_t r);
    logic        ifu_wait;
    logic        lsu_wait;
    int          ifu_at;
    int          lsu_at;
    int          cyc;
    int          tx_before;
    int          errs_before;
    logic [31:0] ifu_data;
    logic [31:0] lsu_data;
    logic [31:0] exp;
    string       who_s;
    who_s = (r.who == REQ_IFU) ? "ifu" : (r.who == REQ_LSU) ? "lsu" : "both";
    errs_before = errors;
    tx_before   = tx_count;
    ifu_at      = 0;
    lsu_at      = 0;
    ifu_data    = '0;
    lsu_data    = '0;
    ifu_wait    = (r.who != REQ_LSU);
    lsu_wait    = (r.who != REQ_IFU);
    repeat (r.gap) @(posedge clk);
    @(posedge clk);
    if (ifu_wait)
      ifu_req <= '{valid: 1'b1, addr: (r.who == REQ_BOTH) ? r.addr2 : r.addr};
    if (lsu_wait)
      lsu_req <= '{valid: 1'b1, write: r.wr, addr: r.addr, wdata: r.wdata, wstrb: r.wstrb};
    // responses sampled mid-cycle, requests dropped on the next edge
    for (cyc = 0; cyc < TIMEOUT && (ifu_wait || lsu_wait); cyc++)
    begin
      @(negedge clk);
      if (lsu_wait && lsu_rsp.valid)
      begin
        lsu_wait = 1'b0;
        lsu_at   = cyc;
        lsu_data = lsu_rsp.rdata;
      end
      if (ifu_wait && ifu_rsp.valid)
      begin
        ifu_wait = 1'b0;
        ifu_at   = cyc;
        ifu_data = ifu_rsp.data;
      end
      @(posedge clk);
      if (!lsu_wait)
        lsu_req.valid <= 1'b0;
      if (!ifu_wait)
        ifu_req.valid <= 1'b0;
    end
    if (ifu_wait || lsu_wait)
    begin
      $display("row %0d: timeout, no response within %0d cycles", n, TIMEOUT);
      errors++;
      failed++;
      timed_out = 1'b1;
      ifu_req.valid <= 1'b0;
      lsu_req.valid <= 1'b0;
      return;
    end
    // lsu side first, a write here is seen by the ifu read of the same row
    if (r.who != REQ_IFU)
    begin
      if (r.wr)
      begin
        assert (lsu_data === 32'h0)
        else fail_check(n, $sformatf("write rdata %h, expected 0", lsu_data));
        if (r.addr != SERIAL_ADDR)
          ref_mem[r.addr[12:2]] = merge_bytes(ref_mem[r.addr[12:2]], r.wdata, r.wstrb);
      end
      else if (r.chk == CHK_RISE)
      begin
        assert (lsu_data > last_lo)
        else fail_check(n, $sformatf("mtime %h not above %h", lsu_data, last_lo));
        last_lo = lsu_data;
      end
      else
      begin
        exp = (r.chk == CHK_VALUE) ? r.exp : ref_mem[r.addr[12:2]];
        assert (lsu_data === exp)
        else fail_check(n, $sformatf("lsu rdata %h, expected %h", lsu_data, exp));
      end
    end
    if (r.chk == CHK_TX)
    begin
      tx_expect++;
      assert (tx_count - tx_before == 1)
      else fail_check(n, $sformatf("%0d serial bytes, expected 1", tx_count - tx_before));
      assert (tx_last === r.exp[7:0])
      else fail_check(n, $sformatf("serial byte %h, expected %h", tx_last, r.exp[7:0]));
    end
    if (r.who != REQ_LSU)
    begin
      exp = ref_mem[(r.who == REQ_BOTH) ? r.addr2[12:2] : r.addr[12:2]];
      assert (ifu_data === exp)
      else fail_check(n, $sformatf("ifu data %h, expected %h", ifu_data, exp));
    end
    if (r.who == REQ_BOTH)
    begin
      assert (lsu_at <= ifu_at)
      else fail_check(n, $sformatf("lsu done at %0d, after ifu at %0d", lsu_at, ifu_at));
    end
    if (errors == errs_before)
      passed++;
    else
      failed++;
    $display("row %2d %-4s %s %h: %s", n, who_s, r.wr ? "wr" : "rd", r.addr,
             (errors == errs_before) ? "pass" : "fail");
  endtask

  initial
  begin
    logic [31:0] word;
    rst       = 1'b1;
    ifu_req   = '0;
    lsu_req   = '0;
    seed      = 32'h7ed5;
    errors    = 0;
    passed    = 0;
    failed    = 0;
    tx_count  = 0;
    tx_expect = 0;
    last_lo   = '0;
    timed_out = 1'b0;

    // who, wr, addr, ifu addr, wdata, strobes, expected, check, idle cycles before
    add_row(REQ_LSU, 1'b0, MTIME_HI_ADDR, '0, '0, 4'hf, 32'h0, CHK_VALUE, 0);
    add_row(REQ_LSU, 1'b1, 32'h100, '0, $random(seed), 4'hf, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b1, 32'h104, '0, $random(seed), 4'hf, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b1, 32'h108, '0, $random(seed), 4'hf, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b1, 32'h10c, '0, $random(seed), 4'hf, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b0, 32'h100, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    add_row(REQ_LSU, 1'b0, 32'h104, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    add_row(REQ_LSU, 1'b0, 32'h108, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    add_row(REQ_LSU, 1'b0, 32'h10c, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    // partial writes on both lanes, then merged read back
    add_row(REQ_LSU, 1'b1, 32'h100, '0, $random(seed), 4'b0010, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b1, 32'h100, '0, $random(seed), 4'b1100, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b1, 32'h104, '0, $random(seed), 4'b0100, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b1, 32'h104, '0, $random(seed), 4'b0011, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b1, 32'h10c, '0, $random(seed), 4'b1000, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b0, 32'h100, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    add_row(REQ_LSU, 1'b0, 32'h104, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    add_row(REQ_LSU, 1'b0, 32'h10c, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    // fetches of lsu data
    add_row(REQ_IFU, 1'b0, 32'h104, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    add_row(REQ_IFU, 1'b0, 32'h108, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    // same-cycle requests
    add_row(REQ_BOTH, 1'b0, 32'h100, 32'h10c, '0, 4'hf, '0, CHK_MODEL, 0);
    add_row(REQ_BOTH, 1'b1, 32'h108, 32'h108, $random(seed), 4'hf, '0, CHK_NONE, 0);
    // serial write must not touch SRAM word 0
    add_row(REQ_LSU, 1'b1, 32'h000, '0, $random(seed), 4'hf, '0, CHK_NONE, 0);
    add_row(REQ_LSU, 1'b1, 32'h004, '0, $random(seed), 4'hf, '0, CHK_NONE, 0);
    word = $random(seed);
    add_row(REQ_LSU, 1'b1, SERIAL_ADDR, '0, word, 4'hf, {24'h0, word[7:0]}, CHK_TX, 0);
    add_row(REQ_LSU, 1'b0, 32'h000, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    add_row(REQ_LSU, 1'b0, 32'h004, '0, '0, 4'hf, '0, CHK_MODEL, 0);
    // timer low half keeps rising
    add_row(REQ_LSU, 1'b0, MTIME_LO_ADDR, '0, '0, 4'hf, '0, CHK_RISE, 0);
    add_row(REQ_LSU, 1'b0, MTIME_LO_ADDR, '0, '0, 4'hf, '0, CHK_RISE, 10);

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < rows.size() && !timed_out; i++)
    begin
      apply_row(i, rows[i]);
    end

    repeat (3) @(posedge clk);
    assert (tx_count == tx_expect)
    else fail_check(-1, $sformatf("%0d serial bytes in total, expected %0d",
                                  tx_count, tx_expect));

    $display("rows: %0d passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- flist.f
rtl/bus_pkg.sv
rtl/core_if_pkg.sv
rtl/clint_timer.sv
rtl/serial_tx_port.sv
rtl/axi_sram.sv
rtl/bus_arbiter.sv
rtl/mem_subsys_top.sv
dv/tb_mem_subsys.sv

//--- rtl/axi_sram.sv
`timescale 1ns/1ps

module axi_sram
  import bus_pkg::*;
#(
  parameter int SRAM_WORDS = 1024,
  parameter int READ_LAT   = 2
) (
  input  logic      clk,
  input  logic      rst,
  input  axi_ar_t   ar_i,
  output logic      arready_o,
  output axi_r_t    r_o,
  input  axi_aw_w_t aw_w_i,
  output logic      awready_o,
  output axi_b_t    b_o
);

  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  logic [63:0]         mem [SRAM_WORDS];
  logic [63:0]         rd_data_q [READ_LAT];
  logic [READ_LAT-1:0] rd_vld_q;
  logic                rd_pend;
  logic                b_vld_q;
  logic                ar_hs;
  logic                aw_hs;
  logic [IDX_W-1:0]    ar_idx;
  logic [IDX_W-1:0]    aw_idx;

  // one 64-bit word per index
  assign ar_idx = ar_i.addr[3 +: IDX_W];
  assign aw_idx = aw_w_i.addr[3 +: IDX_W];

  assign rd_pend   = |rd_vld_q;
  assign arready_o = !rd_pend;
  assign awready_o = !rd_pend && !b_vld_q;

  assign ar_hs = ar_i.valid && arready_o;
  assign aw_hs = aw_w_i.valid && awready_o;

  // strobed byte writes
  always_ff @(posedge clk)
  begin
    if (aw_hs)
    begin
      for (int i = 0; i < 8; i++)
      begin
        if (aw_w_i.strb[i])
          mem[aw_idx][8*i +: 8] <= aw_w_i.data[8*i +: 8];
      end
    end
  end

  // read data delay line
  always_ff @(posedge clk)
  begin
    if (ar_hs)
      rd_data_q[0] <= mem[ar_idx];
    for (int i = 1; i < READ_LAT; i++)
    begin
      rd_data_q[i] <= rd_data_q[i-1];
    end
  end

  // pending flag follows the data down the line
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_vld_q <= '0;
      b_vld_q  <= 1'b0;
    end
    else
    begin
      rd_vld_q[0] <= ar_hs;
      for (int i = 1; i < READ_LAT; i++)
      begin
        rd_vld_q[i] <= rd_vld_q[i-1];
      end
      b_vld_q <= aw_hs;
    end
  end

  assign r_o = '{
    valid: rd_vld_q[READ_LAT-1],
    resp:  AXI_RESP_OKAY,
    data:  rd_data_q[READ_LAT-1]
  };

  assign b_o = '{valid: b_vld_q, resp: AXI_RESP_OKAY};

  // decode sends everything unmapped here, so the address must fit
  a_ar_range: assert property (@(posedge clk) disable iff (rst)
    ar_hs |-> (ar_i.addr[31:3] < SRAM_WORDS));

  a_aw_range: assert property (@(posedge clk) disable iff (rst)
    aw_hs |-> (aw_w_i.addr[31:3] < SRAM_WORDS));

endmodule

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
  import bus_pkg::*;
  import core_if_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  ifu_req_t    ifu_req_i,
  output ifu_rsp_t    ifu_rsp_o,
  input  lsu_req_t    lsu_req_i,
  output lsu_rsp_t    lsu_rsp_o,
  output axi_ar_t     ar_o,
  input  logic        arready_i,
  input  axi_r_t      r_i,
  output axi_aw_w_t   aw_w_o,
  input  logic        awready_i,
  input  axi_b_t      b_i,
  output logic        clint_rd_o,
  output logic        clint_hi_o,
  input  logic [31:0] clint_rdata_i,
  input  logic        clint_rvalid_i,
  output logic        serial_wr_o,
  output logic [7:0]  serial_data_o,
  input  logic        serial_ack_i
);

  arb_state_e  state_q;
  arb_state_e  state_d;
  logic        idle;
  logic        rsp_done;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  wstrb_q;
  acc_size_e   size_q;
  logic        ar_vld_q;
  logic        aw_vld_q;
  logic        clint_rd_q;
  logic        serial_wr_q;
  logic [31:0] r_lane;

  // size from how many strobes are set
  function automatic acc_size_e strb_to_size(input logic [3:0] strb);
    case (strb)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: strb_to_size = SZ_BYTE;
      4'b0011, 4'b1100:                   strb_to_size = SZ_HALF;
      default:                            strb_to_size = SZ_WORD;
    endcase
  endfunction

  assign idle = (state_q == ST_IDLE);

  // addr bit 2 picks the 32-bit lane of the beat
  assign r_lane = addr_q[2] ? r_i.data[63:32] : r_i.data[31:0];

  // responses go back in the cycle they arrive
  always_comb
  begin
    ifu_rsp_o = '0;
    lsu_rsp_o = '0;
    case (state_q)
      ST_IFU_RD:    ifu_rsp_o = '{valid: r_i.valid, data: r_lane};
      ST_LSU_RD:    lsu_rsp_o = '{valid: r_i.valid, rdata: r_lane};
      ST_CLINT_RD:  lsu_rsp_o = '{valid: clint_rvalid_i, rdata: clint_rdata_i};
      ST_SRAM_WR:   lsu_rsp_o.valid = b_i.valid;
      ST_SERIAL_WR: lsu_rsp_o.valid = serial_ack_i;
      default:      ;
    endcase
  end

  assign rsp_done = ifu_rsp_o.valid | lsu_rsp_o.valid;

  // grant in idle, lsu first, target chosen by address
  always_comb
  begin
    state_d = state_q;
    if (idle)
    begin
      if (lsu_req_i.valid)
      begin
        if (lsu_req_i.write)
        begin
          if (lsu_req_i.addr == SERIAL_ADDR)
            state_d = ST_SERIAL_WR;
          else
            state_d = ST_SRAM_WR;
        end
        else if (lsu_req_i.addr == MTIME_LO_ADDR || lsu_req_i.addr == MTIME_HI_ADDR)
          state_d = ST_CLINT_RD;
        else
          state_d = ST_LSU_RD;
      end
      else if (ifu_req_i.valid)
        state_d = ST_IFU_RD;
    end
    else if (rsp_done)
      state_d = ST_IDLE;
  end

  // capture the request that wins the grant
  always_ff @(posedge clk)
  begin
    if (idle)
    begin
      if (lsu_req_i.valid)
      begin
        addr_q  <= lsu_req_i.addr;
        wdata_q <= lsu_req_i.wdata;
        wstrb_q <= lsu_req_i.wstrb;
        size_q  <= strb_to_size(lsu_req_i.wstrb);
      end
      else
      begin
        // fetches are always full words
        addr_q  <= ifu_req_i.addr;
        wdata_q <= '0;
        wstrb_q <= 4'hf;
        size_q  <= SZ_WORD;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= ST_IDLE;
      ar_vld_q    <= 1'b0;
      aw_vld_q    <= 1'b0;
      clint_rd_q  <= 1'b0;
      serial_wr_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // single-cycle strobes right after the grant
      clint_rd_q  <= idle && (state_d == ST_CLINT_RD);
      serial_wr_q <= idle && (state_d == ST_SERIAL_WR);
      // valid held until the handshake
      if (idle && (state_d == ST_IFU_RD || state_d == ST_LSU_RD))
        ar_vld_q <= 1'b1;
      else if (arready_i)
        ar_vld_q <= 1'b0;
      if (idle && state_d == ST_SRAM_WR)
        aw_vld_q <= 1'b1;
      else if (awready_i)
        aw_vld_q <= 1'b0;
    end
  end

  assign ar_o = '{valid: ar_vld_q, addr: addr_q, size: size_q};

  // data goes on both lanes, the strobes select the half
  assign aw_w_o = '{
    valid: aw_vld_q,
    addr:  addr_q,
    size:  size_q,
    data:  {wdata_q, wdata_q},
    strb:  addr_q[2] ? {wstrb_q, 4'b0000} : {4'b0000, wstrb_q}
  };

  assign clint_rd_o    = clint_rd_q;
  assign clint_hi_o    = (addr_q == MTIME_HI_ADDR);
  assign serial_wr_o   = serial_wr_q;
  assign serial_data_o = wdata_q[7:0];

  // the SRAM never reports an error
  a_r_okay: assert property (@(posedge clk) disable iff (rst)
    r_i.valid |-> (r_i.resp == AXI_RESP_OKAY));

  a_b_okay: assert property (@(posedge clk) disable iff (rst)
    b_i.valid |-> (b_i.resp == AXI_RESP_OKAY));

  // SRAM read beats only arrive for the read in flight
  a_r_expected: assert property (@(posedge clk) disable iff (rst)
    r_i.valid |-> (state_q == ST_IFU_RD || state_q == ST_LSU_RD));

endmodule

//--- rtl/bus_pkg.sv
package bus_pkg;

  // address map
  // the serial port and the timer each take single words, SRAM takes the rest
  localparam logic [31:0] SERIAL_ADDR   = 32'h1000_0000;
  localparam logic [31:0] MTIME_LO_ADDR = 32'h0200_bff8;
  localparam logic [31:0] MTIME_HI_ADDR = 32'h0200_bffc;

  // only OKAY is ever returned
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // read address channel
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [2:0]  size;
  } axi_ar_t;

  // read data channel
  typedef struct packed {
    logic        valid;
    logic [1:0]  resp;
    logic [63:0] data;
  } axi_r_t;

  // write address and write data travel together
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [2:0]  size;
    logic [63:0] data;
    logic [7:0]  strb;
  } axi_aw_w_t;

  // write response channel
  typedef struct packed {
    logic       valid;
    logic [1:0] resp;
  } axi_b_t;

  // one state per transaction kind, one transaction in flight
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_IFU_RD,
    ST_LSU_RD,
    ST_CLINT_RD,
    ST_SRAM_WR,
    ST_SERIAL_WR
  } arb_state_e;

endpackage

//--- rtl/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_i,
  input  logic        hi_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  localparam int MTIME_W = 64;

  logic [MTIME_W-1:0] mtime;

  // free-running, one tick per clock
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime    <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      mtime    <= mtime + 1'b1;
      rvalid_o <= rd_i;
    end
  end

  // half selected at the strobe
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (hi_i)
        rdata_o <= mtime[MTIME_W-1:32];
      else
        rdata_o <= mtime[31:0];
    end
  end

endmodule

//--- rtl/core_if_pkg.sv
package core_if_pkg;

  // encoding matches the AXI size field
  typedef enum logic [2:0] {
    SZ_BYTE = 3'b000,
    SZ_HALF = 3'b001,
    SZ_WORD = 3'b010
  } acc_size_e;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } ifu_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } ifu_rsp_t;

  // strobes also qualify reads, they set the access size
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } lsu_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } lsu_rsp_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } uart_tx_t;

endpackage

//--- rtl/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top
  import bus_pkg::*;
  import core_if_pkg::*;
#(
  parameter int SRAM_WORDS = 1024,
  parameter int READ_LAT   = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  ifu_req_t ifu_req_i,
  output ifu_rsp_t ifu_rsp_o,
  input  lsu_req_t lsu_req_i,
  output lsu_rsp_t lsu_rsp_o,
  output uart_tx_t uart_tx_o
);

  // SRAM channels
  axi_ar_t     ar;
  logic        arready;
  axi_r_t      r;
  axi_aw_w_t   aw_w;
  logic        awready;
  axi_b_t      b;

  // timer and serial port
  logic        clint_rd;
  logic        clint_hi;
  logic [31:0] clint_rdata;
  logic        clint_rvalid;
  logic        serial_wr;
  logic [7:0]  serial_data;
  logic        serial_ack;

  bus_arbiter u_bus_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_req_i      (ifu_req_i),
    .ifu_rsp_o      (ifu_rsp_o),
    .lsu_req_i      (lsu_req_i),
    .lsu_rsp_o      (lsu_rsp_o),
    .ar_o           (ar),
    .arready_i      (arready),
    .r_i            (r),
    .aw_w_o         (aw_w),
    .awready_i      (awready),
    .b_i            (b),
    .clint_rd_o     (clint_rd),
    .clint_hi_o     (clint_hi),
    .clint_rdata_i  (clint_rdata),
    .clint_rvalid_i (clint_rvalid),
    .serial_wr_o    (serial_wr),
    .serial_data_o  (serial_data),
    .serial_ack_i   (serial_ack)
  );

  axi_sram #(
    .SRAM_WORDS (SRAM_WORDS),
    .READ_LAT   (READ_LAT)
  ) u_axi_sram (
    .clk       (clk),
    .rst       (rst),
    .ar_i      (ar),
    .arready_o (arready),
    .r_o       (r),
    .aw_w_i    (aw_w),
    .awready_o (awready),
    .b_o       (b)
  );

  clint_timer u_clint_timer (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (clint_rd),
    .hi_i     (clint_hi),
    .rdata_o  (clint_rdata),
    .rvalid_o (clint_rvalid)
  );

  serial_tx_port u_serial_tx_port (
    .clk    (clk),
    .rst    (rst),
    .wr_i   (serial_wr),
    .data_i (serial_data),
    .ack_o  (serial_ack),
    .tx_o   (uart_tx_o)
  );

endmodule

//--- rtl/serial_tx_port.sv
`timescale 1ns/1ps

module serial_tx_port
  import core_if_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       wr_i,
  input  logic [7:0] data_i,
  output logic       ack_o,
  output uart_tx_t   tx_o
);

  logic       vld_q;
  logic [7:0] data_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      vld_q <= 1'b0;
    else
      vld_q <= wr_i;
  end

  always_ff @(posedge clk)
  begin
    if (wr_i)
      data_q <= data_i;
  end

  // byte and ack leave together, one cycle wide
  assign ack_o = vld_q;
  assign tx_o  = '{valid: vld_q, data: data_q};

  // the arbiter waits for the ack before its next write
  a_no_wr_during_ack: assert property (@(posedge clk) disable iff (rst)
    ack_o |-> !wr_i);

endmodule
